//--- verilog/mcp_pkg.sv
// LSI-11 data chip microinstruction decode
// shared widths, flag and dmi bit indices, phase, opcode and branch encodings

package mcp_pkg;

   localparam int MIR_W = 16;   // microinstruction
   localparam int OP_W  = 8;    // opcode byte mir[15:8]
   localparam int PSW_W = 8;    // ALU/status flags
   localparam int DMI_W = 11;   // decoded instruction classes
   localparam int DAL_W = 5;    // dal[15,11,10,9,8]

   // flag vector order is NB ZB C4 C8 N Z V C, msb first
   localparam int PSW_C  = 0;
   localparam int PSW_V  = 1;
   localparam int PSW_Z  = 2;
   localparam int PSW_N  = 3;
   localparam int PSW_C8 = 4;
   localparam int PSW_ZB = 6;
   localparam int PSW_NB = 7;

   localparam int DMI_CAWI  = 0;    // cawi
   localparam int DMI_CMP   = 1;    // cmb/cmw/cab/caw
   localparam int DMI_SRBC  = 2;    // srbc/swrc
   localparam int DMI_CAD   = 3;    // cad
   localparam int DMI_NOP   = 4;    // nop
   localparam int DMI_IO    = 5;    // i/o opcodes
   localparam int DMI_OUT   = 6;    // output
   localparam int DMI_IW    = 7;    // iw
   localparam int DMI_MI    = 8;    // mi
   localparam int DMI_LGL   = 9;    // lgl
   localparam int DMI_ARITH = 10;   // 10xxxxxx

   // classes suppressed while the input enable is latched
   localparam logic [DMI_W-1:0] DMI_GATED = 11'b011_1110_0100;

   typedef enum logic [1:0] {
      PH_C1 = 2'd0,
      PH_C2 = 2'd1,
      PH_C3 = 2'd2,
      PH_C4 = 2'd3
   } phase_e;

   // pairs share a flag, odd code tests it true
   typedef enum logic [OP_W-1:0] {
      JZBF = 8'h10,
      JZBT = 8'h11,
      JC8F = 8'h12,
      JC8T = 8'h13,
      JIF  = 8'h14,
      JIT  = 8'h15,
      JNBF = 8'h16,
      JNBT = 8'h17,
      JZF  = 8'h18,
      JZT  = 8'h19,
      JCF  = 8'h1a,
      JCT  = 8'h1b,
      JVF  = 8'h1c,
      JVT  = 8'h1d,
      JNF  = 8'h1e,
      JNT  = 8'h1f
   } ujmp_op_e;

   // branch groups on dal[4:1]
   typedef enum logic [3:0] {
      BR_ALWAYS = 4'b0000,
      BR_NE_EQ  = 4'b0001,
      BR_GE_LT  = 4'b0010,
      BR_GT_LE  = 4'b0011,
      BR_PL_MI  = 4'b1000,
      BR_HI_LOS = 4'b1001,
      BR_VC_VS  = 4'b1010,
      BR_CC_CS  = 4'b1011
   } br_cond_e;

endpackage

//--- verilog/mcp_phase_if.sv
// phase enables and latched microinstruction fields
// from the phase sequencer to the decode arrays
`timescale 1ns/1ps

interface mcp_phase_if import mcp_pkg::*; ();

   logic            c1;       // phase enables, one hot
   logic            c2;
   logic            c3;
   logic            c4;
   logic [OP_W-1:0] op;       // opcode byte, latched at c2 end
   logic            inpl_l;   // input enable, latched at c2 end

   modport ctrl (
      output c1, c2, c3, c4,
      output op, inpl_l
   );

   modport dp (
      input c1, c2, c3, c4,
      input op, inpl_l
   );

endinterface

//--- verilog/mcp_phase.sv
// phase sequencer for the data chip decoders
// steps c1..c4 on clk and latches opcode byte and input enable at c2 end
`timescale 1ns/1ps

module mcp_phase import mcp_pkg::*;
(
   input  logic             clk,
   input  logic             rst,
   mcp_phase_if.ctrl        ph,
   input  logic [MIR_W-1:0] mir,    // microinstruction
   input  logic             inpl    // input enable
);

   phase_e phase;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         phase <= PH_C1;
      end
      else
      begin
         phase <= phase_e'(phase + 2'd1);   // wraps c4 -> c1
      end
   end

   assign ph.c1 = (phase == PH_C1);
   assign ph.c2 = (phase == PH_C2);
   assign ph.c3 = (phase == PH_C3);
   assign ph.c4 = (phase == PH_C4);

   // fields hold for a full microcycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ph.op     <= '0;
         ph.inpl_l <= 1'b0;
      end
      else if (phase == PH_C2)
      begin
         ph.op     <= mir[MIR_W-1:MIR_W-OP_W];   // mir[15:8]
         ph.inpl_l <= inpl;
      end
   end

endmodule

//--- verilog/mcp_pli.sv
// instruction class decode array of the data chip
// eleven opcode patterns, registered at c3 end
`timescale 1ns/1ps

module mcp_pli import mcp_pkg::*;
(
   input  logic             clk,
   input  logic             rst,
   mcp_phase_if.dp          ph,
   output logic [DMI_W-1:0] dmi     // decoded classes
);

   logic [DMI_W-1:0] pl;
   logic [DMI_W-1:0] pl_gated;

   always_comb
   begin
      pl = '0;
      pl[DMI_CAWI]  = (ph.op ==? 8'b1010111?);
      pl[DMI_CMP]   = (ph.op ==? 8'b10?001??);
      pl[DMI_SRBC]  = (ph.op ==? 8'b110110??);
      pl[DMI_CAD]   = (ph.op ==  8'b10101100);
      pl[DMI_NOP]   = (ph.op ==  8'b11111111);
      pl[DMI_IO]    = (ph.op ==? 8'b1111????);
      pl[DMI_OUT]   = (ph.op ==? 8'b?11111??);
      pl[DMI_IW]    = (ph.op ==? 8'b1110001?);
      pl[DMI_MI]    = (ph.op ==? 8'b111011??);
      pl[DMI_LGL]   = (ph.op ==  8'b01110101);
      pl[DMI_ARITH] = (ph.op ==? 8'b10??????);
   end

   // inpl blocks the i/o related classes only
   assign pl_gated = pl & ~({DMI_W{ph.inpl_l}} & DMI_GATED);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         dmi <= '0;
      end
      else if (ph.c3)
      begin
         dmi <= pl_gated;   // valid c4 .. next c3
      end
   end

endmodule

//--- verilog/mcp_plj.sv
// microjump condition decoder of the data chip
// tests psw flags or icc per opcode pair, jump pulse during c4
`timescale 1ns/1ps

module mcp_plj import mcp_pkg::*;
(
   input  logic             clk,
   input  logic             rst,
   mcp_phase_if.dp          ph,
   input  logic [PSW_W-1:0] psw,     // NB ZB C4 C8 N Z V C
   input  logic             icc,     // indirect condition code
   output logic             ujump    // jump condition met
);

   logic is_ujmp;    // op is one of the sixteen jumps
   logic flag;       // flag selected by opcode pair
   logic cond;
   logic jump_c3;

   always_comb
   begin
      is_ujmp = 1'b1;
      flag    = 1'b0;
      case (ujmp_op_e'(ph.op))
         JZBF, JZBT: flag = psw[PSW_ZB];
         JC8F, JC8T: flag = psw[PSW_C8];
         JIF,  JIT:  flag = icc;
         JNBF, JNBT: flag = psw[PSW_NB];
         JZF,  JZT:  flag = psw[PSW_Z];
         JCF,  JCT:  flag = psw[PSW_C];
         JVF,  JVT:  flag = psw[PSW_V];
         JNF,  JNT:  flag = psw[PSW_N];
         default:    is_ujmp = 1'b0;
      endcase
   end

   // even code jumps on false, odd on true
   assign cond = is_ujmp & (flag == ph.op[0]);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         jump_c3 <= 1'b0;
      end
      else if (ph.c3)
      begin
         jump_c3 <= ~ph.inpl_l & cond;   // psw, icc sampled here
      end
   end

   assign ujump = ph.c4 & jump_c3;

endmodule

//--- verilog/mcp_plb.sv
// PDP-11 conditional branch matrix
// condition latched at c4 end, branch result loaded at next c2 end under mo_ad
`timescale 1ns/1ps

module mcp_plb import mcp_pkg::*;
(
   input  logic             clk,
   input  logic             rst,
   mcp_phase_if.dp          ph,
   input  logic [DAL_W-1:0] dal,     // dal[15,11,10,9,8]
   input  logic [PSW_W-1:0] psw,     // processor status word
   input  logic             mo_ad,   // translate AD to MI bus
   output logic             bjump    // branch taken
);

   logic cond;
   logic jcond_c4;
   logic moad_c1;

   always_comb
   begin
      case (br_cond_e'(dal[4:1]))
         BR_CC_CS:  cond = psw[PSW_C];
         BR_VC_VS:  cond = psw[PSW_V];
         BR_HI_LOS: cond = psw[PSW_Z] | psw[PSW_C];
         BR_PL_MI:  cond = psw[PSW_N];
         BR_GT_LE:  cond = psw[PSW_Z] | (psw[PSW_N] ^ psw[PSW_V]);
         BR_GE_LT:  cond = psw[PSW_N] ^ psw[PSW_V];
         BR_NE_EQ:  cond = psw[PSW_Z];
         BR_ALWAYS: cond = 1'b1;
         default:   cond = 1'b0;   // not a branch group
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         jcond_c4 <= 1'b0;
         moad_c1  <= 1'b0;
         bjump    <= 1'b0;
      end
      else
      begin
         if (ph.c4)
         begin
            jcond_c4 <= cond;
         end
         if (ph.c1)
         begin
            moad_c1 <= mo_ad;
         end
         // dal[0] picks the sense, bne vs beq etc
         if (ph.c2 && moad_c1)
         begin
            bjump <= (jcond_c4 == dal[0]);
         end
      end
   end

endmodule

//--- verilog/mcp_decode.sv
// data chip microinstruction decode top
// phase sequencer with class, microjump and branch decoders
`timescale 1ns/1ps

module mcp_decode import mcp_pkg::*;
(
   input  logic             clk,
   input  logic             rst,
   input  logic [MIR_W-1:0] mir,     // microinstruction
   input  logic             inpl,    // input enable
   input  logic             icc,     // indirect condition code
   input  logic [PSW_W-1:0] psw,     // PSW flags
   input  logic [DAL_W-1:0] dal,     // dal[15,11,10,9,8]
   input  logic             mo_ad,   // translate AD strobe
   output logic             c1,      // start of microcycle
   output logic [DMI_W-1:0] dmi,     // decoded classes
   output logic             ujump,   // microjump taken
   output logic             bjump    // PDP-11 branch taken
);

   mcp_phase_if ph_if ();

   mcp_phase mcp_phase_i
   (
      .clk  (clk),
      .rst  (rst),
      .ph   (ph_if.ctrl),
      .mir  (mir),
      .inpl (inpl)
   );

   mcp_pli mcp_pli_i
   (
      .clk (clk),
      .rst (rst),
      .ph  (ph_if.dp),
      .dmi (dmi)
   );

   mcp_plj mcp_plj_i
   (
      .clk   (clk),
      .rst   (rst),
      .ph    (ph_if.dp),
      .psw   (psw),
      .icc   (icc),
      .ujump (ujump)
   );

   mcp_plb mcp_plb_i
   (
      .clk   (clk),
      .rst   (rst),
      .ph    (ph_if.dp),
      .dal   (dal),
      .psw   (psw),
      .mo_ad (mo_ad),
      .bjump (bjump)
   );

   assign c1 = ph_if.c1;

endmodule

//--- testbench/mcp_decode_sva.sv
// timing assertions for the data chip decode top
// phase period and the cycles in which outputs may change
`timescale 1ns/1ps

module mcp_decode_sva import mcp_pkg::*;
(
   input logic             clk,
   input logic             rst,
   input logic             c1,
   input logic [DMI_W-1:0] dmi,
   input logic             ujump,
   input logic             bjump
);

   int unsigned fail_count = 0;

   // one c1 every four clocks
   c1_period: assert property (@(posedge clk) disable iff (rst)
      !rst && c1 |=> !c1 ##1 !c1 ##1 !c1 ##1 c1)
   else
   begin
      $error("c1 is not periodic with four clocks");
      fail_count++;
   end

   // c4 is three cycles after c1
   ujump_in_c4: assert property (@(posedge clk) disable iff (rst)
      !rst && ujump |-> $past(c1, 3))
   else
   begin
      $error("ujump high outside c4");
      fail_count++;
   end

   dmi_after_c3: assert property (@(posedge clk) disable iff (rst)
      !rst && $changed(dmi) |-> $past(c1, 3))
   else
   begin
      $error("dmi changed outside the cycle after c3");
      fail_count++;
   end

   bjump_after_c2: assert property (@(posedge clk) disable iff (rst)
      !rst && $changed(bjump) |-> $past(c1, 2))
   else
   begin
      $error("bjump changed outside the cycle after c2");
      fail_count++;
   end

endmodule

bind mcp_decode mcp_decode_sva mcp_decode_sva_i
(
   .clk   (clk),
   .rst   (rst),
   .c1    (c1),
   .dmi   (dmi),
   .ujump (ujump),
   .bjump (bjump)
);

//--- testbench/tb_mcp_decode.sv
// testbench for the data chip microinstruction decode
// random microcycles checked against a rule model, with a watchdog
`timescale 1ns/1ps

module tb_mcp_decode import mcp_pkg::*; ();

   localparam int unsigned SEED    = 32'h0d196be1;
   localparam int          N_MC    = 300;               // microcycles
   localparam int          TIMEOUT = N_MC * 16 + 200;   // ns

   logic             clk;
   logic             rst;
   logic [MIR_W-1:0] mir;
   logic             inpl;
   logic             icc;
   logic [PSW_W-1:0] psw;
   logic [DAL_W-1:0] dal;
   logic             mo_ad;
   logic             c1;
   logic [DMI_W-1:0] dmi;
   logic             ujump;
   logic             bjump;

   int unsigned errors = 0;
   logic [3:0]  br_codes [8] = '{4'b0000, 4'b0001, 4'b0010, 4'b0011,
                                 4'b1000, 4'b1001, 4'b1010, 4'b1011};

   mcp_decode mcp_decode_i
   (
      .clk   (clk),
      .rst   (rst),
      .mir   (mir),
      .inpl  (inpl),
      .icc   (icc),
      .psw   (psw),
      .dal   (dal),
      .mo_ad (mo_ad),
      .c1    (c1),
      .dmi   (dmi),
      .ujump (ujump),
      .bjump (bjump)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // {care mask, value} of each class pattern
   function automatic logic [15:0] dmi_pattern(input int k);
      case (k)
         0:       return {8'hfe, 8'hae};   // 1010111x
         1:       return {8'hdc, 8'h84};   // 10x001xx
         2:       return {8'hfc, 8'hd8};   // 110110xx
         3:       return {8'hff, 8'hac};
         4:       return {8'hff, 8'hff};
         5:       return {8'hf0, 8'hf0};   // 1111xxxx
         6:       return {8'h7c, 8'h7c};   // x11111xx
         7:       return {8'hfe, 8'he2};   // 1110001x
         8:       return {8'hfc, 8'hec};   // 111011xx
         9:       return {8'hff, 8'h75};
         10:      return {8'hc0, 8'h80};   // 10xxxxxx
         default: return {8'h00, 8'hff};   // never matches
      endcase
   endfunction

   function automatic logic [DMI_W-1:0] expected_dmi(input logic [OP_W-1:0] op,
                                                     input logic inpl_v);
      logic [15:0]      p;
      logic [DMI_W-1:0] r;
      r = '0;
      for (int k = 0; k < DMI_W; k++)
      begin
         p    = dmi_pattern(k);
         r[k] = ((op & p[15:8]) == p[7:0]) && !(inpl_v && (k inside {2, 5, 6, 7, 8, 9}));
      end
      return r;
   endfunction

   function automatic logic expected_ujump(input logic [OP_W-1:0] op, input logic inpl_v,
                                           input logic [PSW_W-1:0] f, input logic icc_v);
      logic flag;
      if (op[7:4] != 4'h1 || inpl_v)
      begin
         return 1'b0;
      end
      case (op[3:1])   // opcode pair
         3'd0:    flag = f[PSW_ZB];
         3'd1:    flag = f[PSW_C8];
         3'd2:    flag = icc_v;
         3'd3:    flag = f[PSW_NB];
         3'd4:    flag = f[PSW_Z];
         3'd5:    flag = f[PSW_C];
         3'd6:    flag = f[PSW_V];
         default: flag = f[PSW_N];
      endcase
      return flag == op[0];
   endfunction

   function automatic logic expected_bjump(input logic [DAL_W-1:0] d,
                                           input logic [PSW_W-1:0] f);
      logic c;
      case (d[4:1])
         4'b0000: c = 1'b1;
         4'b0001: c = f[PSW_Z];
         4'b0010: c = f[PSW_N] ^ f[PSW_V];
         4'b0011: c = f[PSW_Z] | (f[PSW_N] ^ f[PSW_V]);
         4'b1000: c = f[PSW_N];
         4'b1001: c = f[PSW_Z] | f[PSW_C];
         4'b1010: c = f[PSW_V];
         4'b1011: c = f[PSW_C];
         default: c = 1'b0;
      endcase
      return c == d[0];
   endfunction

   task automatic expect_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp)
      else
      begin
         errors++;
         $display("ERROR %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
      end
   endtask

   initial
   begin
      logic [OP_W-1:0]  op_v;
      logic [PSW_W-1:0] psw_v;
      logic [DAL_W-1:0] dal_v;
      logic             inpl_v;
      logic             icc_v;
      logic             hold;
      logic             exp_bj;
      logic [15:0]      pat;
      int unsigned      sva_fails;
      void'($urandom(SEED));
      rst    = 1'b1;
      mir    = '0;
      inpl   = 1'b0;
      icc    = 1'b0;
      psw    = '0;
      dal    = '0;
      mo_ad  = 1'b0;
      psw_v  = '0;
      dal_v  = '0;
      exp_bj = 1'b0;
      @(posedge clk);
      @(negedge clk);
      expect_eq("reset c1", 1'b1, c1);
      expect_eq("reset dmi", '0, dmi);
      expect_eq("reset ujump", 1'b0, ujump);
      expect_eq("reset bjump", 1'b0, bjump);
      @(posedge clk);
      rst <= 1'b0;
      for (int mc = 0; mc < N_MC; mc++)
      begin
         if (mc < 32)
         begin
            hold = mc[0];   // sweep all groups and senses first
            if (!hold)
            begin
               dal_v = {br_codes[mc[3:1]], mc[4]};
               psw_v = PSW_W'($urandom);
            end
         end
         else
         begin
            hold = ($urandom_range(0, 1) == 1);
            if (!hold)
            begin
               dal_v = DAL_W'($urandom);
               psw_v = PSW_W'($urandom);
            end
         end
         case ($urandom_range(0, 3))
            0: op_v = 8'h10 | OP_W'($urandom_range(0, 15));   // microjumps
            1:
            begin
               pat  = dmi_pattern($urandom_range(0, DMI_W - 1));
               op_v = pat[7:0] | (OP_W'($urandom) & ~pat[15:8]);
            end
            default: op_v = OP_W'($urandom);
         endcase
         inpl_v = ($urandom_range(0, 3) == 0);
         icc_v  = 1'($urandom);
         mir   <= {op_v, 8'($urandom)};
         inpl  <= inpl_v;
         icc   <= icc_v;
         psw   <= psw_v;
         dal   <= dal_v;
         mo_ad <= hold;
         if (hold)
         begin
            exp_bj = expected_bjump(dal_v, psw_v);   // dal, psw from last microcycle
         end
         @(negedge clk);
         expect_eq("c1 marker", 1'b1, c1);
         if (mc == 0)
         begin
            expect_eq("first dmi", '0, dmi);
            expect_eq("first ujump", 1'b0, ujump);
         end
         repeat (2) @(posedge clk);   // into c3
         @(negedge clk);
         expect_eq("bjump", exp_bj, bjump);
         expect_eq("ujump before c4", 1'b0, ujump);
         @(posedge clk);
         @(negedge clk);
         expect_eq("dmi", expected_dmi(op_v, inpl_v), dmi);
         expect_eq("ujump", expected_ujump(op_v, inpl_v, psw_v, icc_v), ujump);
         @(posedge clk);
      end
      sva_fails = mcp_decode_i.mcp_decode_sva_i.fail_count;
      $display("%0d microcycles, %0d check errors, %0d assertion failures",
               N_MC, errors, sva_fails);
      if (errors == 0 && sva_fails == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

   initial
   begin
      #(TIMEOUT);
      $display("timeout: run did not finish within %0d ns", TIMEOUT);
      $display("sim failed");
      $finish;
   end

endmodule

//--- flist.f
verilog/mcp_pkg.sv
verilog/mcp_phase_if.sv
verilog/mcp_phase.sv
verilog/mcp_pli.sv
verilog/mcp_plj.sv
verilog/mcp_plb.sv
verilog/mcp_decode.sv
testbench/mcp_decode_sva.sv
testbench/tb_mcp_decode.sv

//--- Bender.yml
package:
  name: mcp_decode

sources:
  - verilog/mcp_pkg.sv
  - verilog/mcp_phase_if.sv
  - verilog/mcp_phase.sv
  - verilog/mcp_pli.sv
  - verilog/mcp_plj.sv
  - verilog/mcp_plb.sv
  - verilog/mcp_decode.sv
  - target: simulation
    files:
      - testbench/mcp_decode_sva.sv
      - testbench/tb_mcp_decode.sv
